//--- hdl/isaPkg.sv
`default_nettype none

package isaPkg;

    // instruction field widths
    localparam int opcodeWidth    = 6;
    localparam int functWidth     = 6;
    localparam int regAddrWidth   = 5;
    localparam int immWidth       = 16;
    localparam int jumpIndexWidth = 26;

    typedef logic [regAddrWidth-1:0] regAddrT;

    typedef enum logic [opcodeWidth-1:0] {
        OP_RTYPE = 6'b000000,
        OP_J     = 6'b000010,
        OP_BEQ   = 6'b000100,
        OP_BNE   = 6'b000101,
        OP_ADDIU = 6'b001001,
        OP_ANDI  = 6'b001100,
        OP_ORI   = 6'b001101,
        OP_XORI  = 6'b001110,
        OP_LUI   = 6'b001111,
        OP_LW    = 6'b100011,
        OP_SW    = 6'b101011
    } opcodeT;

    // function field of the R-type subset
    typedef enum logic [functWidth-1:0] {
        FN_JR   = 6'b001000,
        FN_ADDU = 6'b100001,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_SLT  = 6'b101010,
        FN_SLTU = 6'b101011
    } functT;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLTU, ALU_LUI, ALU_PASSA
    } aluOpT;

endpackage

`default_nettype wire

//--- hdl/cpuPkg.sv
`default_nettype none

package cpuPkg;

    typedef logic [31:0] wordT;

    typedef enum logic [2:0] {
        S_FETCH     = 3'b000,
        S_DECODE    = 3'b001,
        S_EXECUTE   = 3'b010,
        S_MEMORY    = 3'b011,
        S_WRITEBACK = 3'b100,
        S_HALTED    = 3'b111
    } cpuStateT;

    localparam wordT resetVector = 32'hBFC00000;
    localparam wordT haltAddress = 32'h00000000; // fetching here stops the cpu

    localparam logic [3:0] byteEnAll = 4'b1111;

endpackage

`default_nettype wire

//--- hdl/instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecoder
    import isaPkg::*;
    import cpuPkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      loadInstr,
    input  wordT                      readdata,
    output opcodeT                    opcode,
    output functT                     funct,
    output regAddrT                   rs,
    output regAddrT                   rt,
    output regAddrT                   destReg,
    output wordT                      immValue,
    output logic [jumpIndexWidth-1:0] jumpIndex,
    output wordT                      branchOffset,
    output aluOpT                     aluOp,
    output logic                      useImm,
    output logic                      regWrite,
    output logic                      isLoad,
    output logic                      isStore,
    output logic                      isBranchEq,
    output logic                      isBranchNe,
    output logic                      isJump,
    output logic                      isJumpReg
);

    wordT instr;
    logic [immWidth-1:0] imm16;
    logic zeroExt;

    // instruction register, loaded from the fetch read data in decode
    always_ff @(posedge clk) begin
        if (reset) begin
            instr <= '0;
        end else if (loadInstr) begin
            instr <= readdata;
        end
    end

    assign opcode    = opcodeT'(instr[31:26]);
    assign funct     = functT'(instr[5:0]);
    assign rs        = instr[25:21];
    assign rt        = instr[20:16];
    assign destReg   = (opcode == OP_RTYPE) ? instr[15:11] : instr[20:16];
    assign jumpIndex = instr[jumpIndexWidth-1:0];
    assign imm16     = instr[immWidth-1:0];

    // logical immediates are zero extended, the rest sign extended
    assign zeroExt      = opcode inside {OP_ANDI, OP_ORI, OP_XORI};
    assign immValue     = zeroExt ? {16'b0, imm16} : {{16{imm16[15]}}, imm16};
    assign branchOffset = {{14{imm16[15]}}, imm16, 2'b00}; // word offset to bytes

    assign useImm     = !(opcode inside {OP_RTYPE, OP_BEQ, OP_BNE});
    assign isLoad     = (opcode == OP_LW);
    assign isStore    = (opcode == OP_SW);
    assign isBranchEq = (opcode == OP_BEQ);
    assign isBranchNe = (opcode == OP_BNE);
    assign isJump     = (opcode == OP_J);
    assign isJumpReg  = (opcode == OP_RTYPE) && (funct == FN_JR);

    always_comb begin
        aluOp    = ALU_PASSA;
        regWrite = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                case (funct)
                    FN_ADDU: aluOp = ALU_ADD;
                    FN_SUBU: aluOp = ALU_SUB;
                    FN_AND:  aluOp = ALU_AND;
                    FN_OR:   aluOp = ALU_OR;
                    FN_XOR:  aluOp = ALU_XOR;
                    FN_SLT:  aluOp = ALU_SLT;
                    FN_SLTU: aluOp = ALU_SLTU;
                    default: aluOp = ALU_PASSA; // jr and unknown codes
                endcase
                regWrite = (aluOp != ALU_PASSA);
            end
            OP_BEQ, OP_BNE: aluOp = ALU_SUB; // zero flag decides the branch
            OP_ADDIU: begin
                aluOp    = ALU_ADD;
                regWrite = 1'b1;
            end
            OP_ANDI: begin
                aluOp    = ALU_AND;
                regWrite = 1'b1;
            end
            OP_ORI: begin
                aluOp    = ALU_OR;
                regWrite = 1'b1;
            end
            OP_XORI: begin
                aluOp    = ALU_XOR;
                regWrite = 1'b1;
            end
            OP_LUI: begin
                aluOp    = ALU_LUI;
                regWrite = 1'b1;
            end
            OP_LW: begin
                aluOp    = ALU_ADD; // base plus offset
                regWrite = 1'b1;
            end
            OP_SW:   aluOp = ALU_ADD;
            default: aluOp = ALU_PASSA;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile
    import isaPkg::*;
    import cpuPkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  regAddrT readAddrA,
    input  regAddrT readAddrB,
    input  logic    writeEnable,
    input  regAddrT writeAddr,
    input  wordT    writeData,
    output wordT    readDataA,
    output wordT    readDataB,
    output wordT    registerV0
);

    wordT regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && (writeAddr != 5'd0)) begin
            regs[writeAddr] <= writeData; // $zero is never written
        end
    end

    assign readDataA  = regs[readAddrA];
    assign readDataB  = regs[readAddrB];
    assign registerV0 = regs[2];

endmodule

`default_nettype wire

//--- hdl/aluUnit.sv
`timescale 1ns/1ps
`default_nettype none

module aluUnit
    import isaPkg::*;
    import cpuPkg::*;
(
    input  aluOpT aluOp,
    input  wordT  a,
    input  wordT  b,
    output wordT  result,
    output logic  zero
);

    always_comb begin
        case (aluOp)
            ALU_ADD:   result = a + b;
            ALU_SUB:   result = a - b;
            ALU_AND:   result = a & b;
            ALU_OR:    result = a | b;
            ALU_XOR:   result = a ^ b;
            ALU_SLT:   result = {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU:  result = {31'b0, a < b};
            ALU_LUI:   result = {b[15:0], 16'b0}; // immediate to the upper half
            ALU_PASSA: result = a;
            default:   result = a;
        endcase
    end

    // beq/bne look at this after the subtraction
    assign zero = (result == '0);

endmodule

`default_nettype wire

//--- hdl/cpuControl.sv
`timescale 1ns/1ps
`default_nettype none

module cpuControl
    import isaPkg::*;
    import cpuPkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      waitrequest,
    input  wordT                      readdata,
    input  wordT                      aluResult,
    input  logic                      aluZero,
    input  wordT                      regReadA,
    input  logic [jumpIndexWidth-1:0] jumpIndex,
    input  wordT                      branchOffset,
    input  regAddrT                   destReg,
    input  logic                      regWrite,
    input  logic                      isLoad,
    input  logic                      isStore,
    input  logic                      isBranchEq,
    input  logic                      isBranchNe,
    input  logic                      isJump,
    input  logic                      isJumpReg,
    output cpuStateT                  state,
    output wordT                      pc,
    output logic                      loadInstr,
    output logic                      regWriteEnable,
    output regAddrT                   regWriteAddr,
    output wordT                      regWriteData,
    output logic                      active
);

    logic [1:0] branchStep; // 0 idle, 1 branch seen, 2 delay slot in flight
    wordT target;
    wordT pcPlus4;
    logic memBusy;
    logic jumpTaken;
    logic branchTaken;

    assign pcPlus4     = pc + 32'd4;
    assign memBusy     = (isLoad || isStore) && waitrequest;
    assign jumpTaken   = (state == S_EXECUTE) && (isJump || isJumpReg);
    assign branchTaken = (state == S_MEMORY)
                         && ((isBranchEq && aluZero) || (isBranchNe && !aluZero));

    assign loadInstr = (state == S_DECODE);
    assign active    = (state != S_HALTED);

    // load data arrives the cycle after the memory read is accepted
    assign regWriteEnable = (state == S_WRITEBACK) && regWrite;
    assign regWriteAddr   = destReg;
    assign regWriteData   = isLoad ? readdata : aluResult;

    always_ff @(posedge clk) begin
        if (jumpTaken) begin
            target <= isJumpReg ? regReadA : {pcPlus4[31:28], jumpIndex, 2'b00};
        end else if (branchTaken) begin
            target <= pcPlus4 + branchOffset;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= S_FETCH;
            pc         <= resetVector;
            branchStep <= 2'd0;
        end else begin
            case (state)
                S_FETCH: begin
                    if (pc == haltAddress) begin
                        state <= S_HALTED;
                    end else if (!waitrequest) begin
                        state <= S_DECODE;
                    end
                end
                S_DECODE:  state <= S_EXECUTE;
                S_EXECUTE: begin
                    if (jumpTaken) branchStep <= 2'd1;
                    state <= S_MEMORY;
                end
                S_MEMORY: begin
                    if (branchTaken) branchStep <= 2'd1;
                    if (!memBusy) state <= S_WRITEBACK; // only lw/sw can stall here
                end
                S_WRITEBACK: begin
                    // delay slot runs from pc+4, the target is taken after it
                    if (branchStep == 2'd2) begin
                        pc         <= target;
                        branchStep <= 2'd0;
                    end else begin
                        pc         <= pcPlus4;
                        branchStep <= (branchStep == 2'd1) ? 2'd2 : 2'd0;
                    end
                    state <= S_FETCH;
                end
                default: state <= S_HALTED; // stays here until reset
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/memAccess.sv
`timescale 1ns/1ps
`default_nettype none

module memAccess
    import cpuPkg::*;
(
    input  cpuStateT   state,
    input  wordT       pc,
    input  wordT       aluResult,
    input  wordT       storeData,
    input  logic       isLoad,
    input  logic       isStore,
    output wordT       address,
    output wordT       writedata,
    output logic       read,
    output logic       write,
    output logic [3:0] byteenable
);

    wordT byteAddr;

    assign byteAddr = (state == S_FETCH) ? pc : aluResult;
    assign address  = {byteAddr[31:2], 2'b00}; // word aligned only

    // no bus request goes out for the fetch from the halt address
    assign read  = ((state == S_FETCH) && (pc != haltAddress))
                   || ((state == S_MEMORY) && isLoad);
    assign write = (state == S_MEMORY) && isStore;

    assign writedata  = storeData;
    assign byteenable = (read || write) ? byteEnAll : 4'b0000;

endmodule

`default_nettype wire

//--- hdl/mipsCpuBus.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCpuBus
    import isaPkg::*;
    import cpuPkg::*;
(
    input  logic       clk,
    input  logic       reset,
    output logic       active,
    output wordT       registerV0,
    output wordT       address,
    output logic       write,
    output logic       read,
    input  logic       waitrequest,
    output wordT       writedata,
    output logic [3:0] byteenable,
    input  wordT       readdata
);

    cpuStateT state;
    wordT pc;
    logic loadInstr;
    regAddrT rs;
    regAddrT rt;
    regAddrT destReg;
    wordT immValue;
    logic [jumpIndexWidth-1:0] jumpIndex;
    wordT branchOffset;
    aluOpT aluOp;
    logic useImm;
    logic regWrite;
    logic isLoad;
    logic isStore;
    logic isBranchEq;
    logic isBranchNe;
    logic isJump;
    logic isJumpReg;
    logic regWriteEnable;
    regAddrT regWriteAddr;
    wordT regWriteData;
    wordT readDataA;
    wordT readDataB;
    wordT aluB;
    wordT aluResult;
    logic aluZero;

    assign aluB = useImm ? immValue : readDataB; // immediate or rt

    instrDecoder u_decoder (
        .clk(clk), .reset(reset), .loadInstr(loadInstr), .readdata(readdata),
        .opcode(), .funct(), .rs(rs), .rt(rt), .destReg(destReg),
        .immValue(immValue), .jumpIndex(jumpIndex), .branchOffset(branchOffset),
        .aluOp(aluOp), .useImm(useImm), .regWrite(regWrite),
        .isLoad(isLoad), .isStore(isStore), .isBranchEq(isBranchEq),
        .isBranchNe(isBranchNe), .isJump(isJump), .isJumpReg(isJumpReg)
    );

    regFile u_regs (
        .clk(clk), .reset(reset), .readAddrA(rs), .readAddrB(rt),
        .writeEnable(regWriteEnable), .writeAddr(regWriteAddr), .writeData(regWriteData),
        .readDataA(readDataA), .readDataB(readDataB), .registerV0(registerV0)
    );

    aluUnit u_alu (
        .aluOp(aluOp), .a(readDataA), .b(aluB), .result(aluResult), .zero(aluZero)
    );

    cpuControl u_control (
        .clk(clk), .reset(reset), .waitrequest(waitrequest), .readdata(readdata),
        .aluResult(aluResult), .aluZero(aluZero), .regReadA(readDataA),
        .jumpIndex(jumpIndex), .branchOffset(branchOffset), .destReg(destReg),
        .regWrite(regWrite), .isLoad(isLoad), .isStore(isStore),
        .isBranchEq(isBranchEq), .isBranchNe(isBranchNe), .isJump(isJump),
        .isJumpReg(isJumpReg), .state(state), .pc(pc), .loadInstr(loadInstr),
        .regWriteEnable(regWriteEnable), .regWriteAddr(regWriteAddr),
        .regWriteData(regWriteData), .active(active)
    );

    memAccess u_mem (
        .state(state), .pc(pc), .aluResult(aluResult), .storeData(readDataB),
        .isLoad(isLoad), .isStore(isStore), .address(address), .writedata(writedata),
        .read(read), .write(write), .byteenable(byteenable)
    );

endmodule

`default_nettype wire

//--- dv/cpuBusProperties.sv
`timescale 1ns/1ps
`default_nettype none

module cpuBusProperties
    import cpuPkg::*;
(
    input logic       clk,
    input logic       reset,
    input logic       read,
    input logic       write,
    input logic       waitrequest,
    input wordT       address,
    input wordT       writedata,
    input logic [3:0] byteenable,
    input logic       active
);

    int failCount = 0; // failed assertions so far

    strobesExclusive: assert property (@(posedge clk) disable iff (reset)
        !(read && write))
        else begin
            $error("read and write are high in the same cycle");
            failCount++;
        end

    // a stalled request keeps address, strobes and data
    requestHeld: assert property (@(posedge clk) disable iff (reset)
        (read || write) && waitrequest |=> $stable(address) && $stable(read)
            && $stable(write) && $stable(writedata) && $stable(byteenable))
        else begin
            $error("bus request changed while waitrequest was high");
            failCount++;
        end

    byteEnableFull: assert property (@(posedge clk) disable iff (reset)
        (read || write) |-> byteenable == byteEnAll)
        else begin
            $error("byteenable is not all ones during a request");
            failCount++;
        end

    // once halted the cpu stays halted and leaves the bus alone
    haltSticky: assert property (@(posedge clk) disable iff (reset)
        !active |=> !active && !read && !write)
        else begin
            $error("cpu left the halted state or used the bus before reset");
            failCount++;
        end

endmodule

bind mipsCpuBus cpuBusProperties u_props (.*);

`default_nettype wire

//--- dv/tbMipsCpuBus.sv
`timescale 1ns/1ps
`default_nettype none

module tbMipsCpuBus
    import cpuPkg::*;
();

    localparam time         clkPeriod     = 100ns;
    localparam time         driveDelay    = 2ns;  // inputs change this long after the edge
    localparam int          resetCycles   = 4;
    localparam int          maxWait       = 3;
    localparam int          idleCycles    = 4;    // bus watched this long after halt
    localparam int          timeoutMargin = 20;   // reset and idle cycles per test
    localparam int unsigned seed          = 32'hb030_6cde;
    localparam string       goldenPath    = "dv/programGolden.txt";

    logic       clk;
    logic       reset;
    logic       waitrequest;
    wordT       readdata;
    logic       active;
    wordT       registerV0;
    wordT       address;
    logic       read;
    logic       write;
    wordT       writedata;
    logic [3:0] byteenable;

    wordT mem [wordT];  // sparse memory keyed by byte address
    logic inRequest   = 1'b0;
    int   waitLeft    = 0;
    logic acceptRead  = 1'b0;
    logic acceptWrite = 1'b0;
    wordT acceptAddr  = '0;
    wordT acceptData  = '0;

    // golden data, one entry per test or per memory word
    string testName [$];
    int    testBudget [$];
    wordT  testV0 [$];
    int    memTest [$];
    wordT  memAddr [$];
    wordT  memData [$];
    int    chkTest [$];
    wordT  chkAddr [$];
    wordT  chkData [$];

    int   cycleCount  = 0;
    int   cycleLimit  = 0;
    int   errorCount  = 0;
    int   testsRun    = 0;
    int   testsFailed = 0;
    logic goldenOk;

    mipsCpuBus u_dut (
        .clk(clk), .reset(reset), .active(active), .registerV0(registerV0),
        .address(address), .write(write), .read(read), .waitrequest(waitrequest),
        .writedata(writedata), .byteenable(byteenable), .readdata(readdata)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleLimit > 0 && cycleCount > cycleLimit) begin
            $display("timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    function automatic wordT readMem(wordT addr);
        return mem.exists(addr) ? mem[addr] : '0;  // unwritten words read as zero
    endfunction

    // bus slave with random wait states
    initial begin
        waitrequest = 1'b0;
        readdata    = '0;
        void'($urandom(seed));
        forever begin
            @(posedge clk);
            #(driveDelay);
            // finish the transfer accepted at this edge
            if (acceptRead) readdata = readMem(acceptAddr);
            if (acceptWrite) mem[acceptAddr] = acceptData;
            acceptRead  = 1'b0;
            acceptWrite = 1'b0;
            if (read || write) begin
                if (!inRequest) begin
                    waitLeft  = $urandom_range(maxWait, 0);
                    inRequest = 1'b1;
                end
                if (waitLeft > 0) begin
                    waitrequest = 1'b1;
                    waitLeft--;
                end else begin
                    waitrequest = 1'b0;  // taken at the next edge
                    inRequest   = 1'b0;
                    acceptRead  = read;
                    acceptWrite = write;
                    acceptAddr  = address;
                    acceptData  = writedata;
                end
            end else begin
                waitrequest = 1'b0;
                inRequest   = 1'b0;
            end
        end
    end

    task automatic compareValue(string what, wordT actual, wordT expected);
        if (actual !== expected) begin
            $display("error: %s is %h, expected %h", what, actual, expected);
            errorCount++;
        end
    endtask

    function automatic bit readGolden();
        int    fd;
        int    count;
        int    need;
        int    budget;
        int    t;
        bit    ok;
        string line;
        string kind;
        string name;
        wordT  addr;
        wordT  value;
        wordT  w [4];
        ok = 1'b1;
        fd = $fopen(goldenPath, "r");
        if (fd == 0) begin
            $display("cannot open the program file %s", goldenPath);
            return 1'b0;
        end
        while ($fgets(line, fd) > 0) begin
            count = $sscanf(line, "%s", kind);
            if (count < 1 || kind.substr(0, 0) == "#") continue;
            t = testName.size() - 1;
            case (kind)
                "test": begin
                    need  = 3;
                    count = $sscanf(line, "%s %s %d", kind, name, budget);
                    testName.push_back(name);
                    testBudget.push_back(budget);
                    testV0.push_back('0);
                    cycleLimit += budget + timeoutMargin;
                end
                "v0": begin
                    need  = 2;
                    count = $sscanf(line, "%s %h", kind, value);
                    if (t >= 0) testV0[t] = value;
                end
                "mem", "chk": begin
                    need  = 6;
                    count = $sscanf(line, "%s %h %h %h %h %h", kind, addr,
                                    w[0], w[1], w[2], w[3]);
                    for (int i = 0; i < 4; i++) begin
                        if (kind == "mem") begin
                            memTest.push_back(t);
                            memAddr.push_back(addr + 4 * i);
                            memData.push_back(w[i]);
                        end else begin
                            chkTest.push_back(t);
                            chkAddr.push_back(addr + 4 * i);
                            chkData.push_back(w[i]);
                        end
                    end
                end
                default: need = -1;
            endcase
            if (count != need || (kind != "test" && t < 0)) begin
                $display("malformed line in the program file: %s", line);
                ok = 1'b0;
            end
        end
        $fclose(fd);
        return ok && (testName.size() > 0);
    endfunction

    task automatic loadMemory(int t);
        mem.delete();
        foreach (memTest[i]) begin
            if (memTest[i] == t) mem[memAddr[i]] = memData[i];
        end
    endtask

    task automatic checkMemory(int t);
        foreach (chkTest[i]) begin
            if (chkTest[i] == t) begin
                compareValue($sformatf("mem[%h]", chkAddr[i]), readMem(chkAddr[i]), chkData[i]);
            end
        end
    endtask

    task automatic runTest(int t);
        int cycles;
        int errorsBefore;
        int assertsBefore;
        errorsBefore  = errorCount;
        assertsBefore = u_dut.u_props.failCount;
        @(posedge clk);
        #(driveDelay);
        reset = 1'b1;
        repeat (2) @(posedge clk);
        loadMemory(t);  // no write can still be in flight here
        repeat (resetCycles - 2) @(posedge clk);
        #(driveDelay);
        reset = 1'b0;
        compareValue("active", active, 32'd1);
        cycles = 0;
        while (active && cycles < testBudget[t]) begin
            @(posedge clk);
            #(driveDelay);
            cycles++;
        end
        if (active) begin
            $display("test %s did not halt within %0d cycles", testName[t], testBudget[t]);
            errorCount++;
        end else begin
            compareValue("registerV0", registerV0, testV0[t]);
            repeat (idleCycles) begin
                @(posedge clk);
                #(driveDelay);
                compareValue("active", active, '0);
                compareValue("read", read, '0);
                compareValue("write", write, '0);
            end
            checkMemory(t);
        end
        errorCount += u_dut.u_props.failCount - assertsBefore; // bus protocol violations
        testsRun++;
        if (errorCount == errorsBefore) begin
            $display("test %s: ok, halted after %0d cycles", testName[t], cycles);
        end else begin
            testsFailed++;
            $display("test %s: failed with %0d errors", testName[t], errorCount - errorsBefore);
        end
    endtask

    initial begin
        reset    = 1'b1;
        goldenOk = readGolden();
        if (goldenOk) begin
            foreach (testName[t]) begin
                runTest(t);
            end
        end
        $display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed, errorCount);
        if (goldenOk && testsRun > 0 && testsFailed == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
hdl/isaPkg.sv
hdl/cpuPkg.sv
hdl/instrDecoder.sv
hdl/regFile.sv
hdl/aluUnit.sv
hdl/cpuControl.sv
hdl/memAccess.sv
hdl/mipsCpuBus.sv
dv/cpuBusProperties.sv
dv/tbMipsCpuBus.sv

//--- Bender.yml
package:
  name: mips_cpu_bus

sources:
  - files:
      - hdl/isaPkg.sv
      - hdl/cpuPkg.sv
      - hdl/instrDecoder.sv
      - hdl/regFile.sv
      - hdl/aluUnit.sv
      - hdl/cpuControl.sv
      - hdl/memAccess.sv
      - hdl/mipsCpuBus.sv
  - target: test
    files:
      - dv/cpuBusProperties.sv
      - dv/tbMipsCpuBus.sv

//--- dv/programGolden.txt
# test <name> <cycle budget>, v0 <expected registerV0 after halt>
# mem = preload, chk = expected after halt: <address> <4 hex words from that address on>
# r-type ops, signed vs unsigned compare, write to $0 ignored
test alu_rtype 220
mem bfc00000 2408fffb 24090003 01095021 01285823
mem bfc00010 0109602a 0109682b 01097024 01097825
mem bfc00020 01098026 01090021 ac0a0100 ac0b0104
mem bfc00030 ac0c0108 ac0d010c ac0e0110 ac0f0114
mem bfc00040 ac100118 00091021 00000008 00000000
v0 00000003
chk 00000100 fffffffe 00000008 00000001 00000000
chk 00000110 00000003 fffffffb fffffff8 00000000
# immediates: lui, ori/andi/xori zero extend, addiu sign extends
test immediates 132
mem bfc00000 3c081234 35088765 25098000 312affff
mem bfc00010 390bf0f0 ac080200 ac090204 ac0a0208
mem bfc00020 ac0b020c 2402ffff 00000008 00000000
v0 ffffffff
chk 00000200 12348765 12340765 00000765 12347795
# lw/sw round trip, sw in the delay slot of jr $0
test load_store 99
mem bfc00000 24080300 8d090000 25290001 ad090008
mem bfc00010 8d020008 8d0a0004 004a1021 00000008
mem bfc00020 ad02000c 00000000 00000000 00000000
mem 00000300 cafef00d 01010101 00000000 00000000
v0 cbfff10f
chk 00000300 cafef00d 01010101 cafef00e cbfff10f
# beq/bne taken and not taken, delay slots always run
test branches 154
mem bfc00000 24080005 24090005 24020000 11090003
mem bfc00010 24420001 24420100 24420200 15090002
mem bfc00020 24420002 24420004 11000002 24420008
mem bfc00030 15000002 24420010 24420400 00000008
mem bfc00040 24420020 00000000 00000000 00000000
v0 0000003f
# j forward, jr back through $t0, jr $0 halts
test jumps 110
mem bfc00000 24020001 0bf00008 24420002 24420100
mem bfc00010 24420010 00000008 24420040 24420200
mem bfc00020 3c08bfc0 35080010 01000008 24420004
mem bfc00030 24420400 00000000 00000000 00000000
v0 00000057
